/* all.f */
+incdir+logic
logic/ts_replace_pkg.sv
logic/pid_filter_table.sv
logic/ts_header_tracker.sv
logic/replace_packet_ram.sv
logic/ts_splicer.sv
logic/ts_replacer_top.sv
verif/ts_replacer_tb.sv

/* logic/pid_filter_table.sv */
`timescale 1ns/1ps
`include "ts_replace_defines.svh"

module pid_filter_table import ts_replace_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      pid_wr,
	input  cfg_word_t pid_index,
	input  cfg_word_t pid_wdata,
	input  pid_t      hdr_pid,
	output cfg_word_t pid_rdata,
	output logic      any_match
);

	localparam int SLOT_W = (`TS_PID_SLOTS > 1) ? $clog2(`TS_PID_SLOTS) : 1;
	localparam int EN_BIT = 16;

	pid_t slot_pid [`TS_PID_SLOTS];
	logic slot_en  [`TS_PID_SLOTS];
	logic index_ok;
	logic [SLOT_W-1:0] slot_sel;

	assign index_ok = (pid_index < `TS_PID_SLOTS);
	assign slot_sel = pid_index[SLOT_W-1:0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `TS_PID_SLOTS; i++) begin
				slot_pid[i] <= '0;
				slot_en[i]  <= 1'b0; // Table comes up disabled.
			end
		end else if (pid_wr && index_ok) begin
			slot_pid[slot_sel] <= pid_wdata[12:0];
			slot_en[slot_sel]  <= pid_wdata[EN_BIT];
		end
	end

	// Readback uses the write layout with unused bits zero.
	always_comb begin
		pid_rdata = '0;
		if (index_ok) begin
			pid_rdata[12:0]   = slot_pid[slot_sel];
			pid_rdata[EN_BIT] = slot_en[slot_sel];
		end
	end

	always_comb begin
		any_match = 1'b0;
		for (int i = 0; i < `TS_PID_SLOTS; i++) begin
			if (slot_en[i] && (slot_pid[i] == hdr_pid)) begin
				any_match = 1'b1;
			end
		end
	end

endmodule

/* logic/replace_packet_ram.sv */
`timescale 1ns/1ps
`include "ts_replace_defines.svh"

module replace_packet_ram import ts_replace_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       data_wr,
	input  cfg_word_t  data_index,
	input  cfg_word_t  data_in,
	input  logic       pump_req,
	input  logic       rd_en,
	input  byte_addr_t rd_addr,
	output ts_byte_t   rd_byte,
	output logic       pump_ready,
	output logic       dump_valid,
	output cfg_word_t  dump_data,
	output cfg_word_t  dump_index
);

	typedef enum logic {DUMP_IDLE, DUMP_RUN} dump_state_t;

	cfg_word_t   mem [`TS_RAM_WORDS];
	dump_state_t dump_state;
	ram_addr_t   dump_ptr;
	ram_addr_t   dump_sel;
	ram_addr_t   rd_word;
	logic        dump_load;

	always_ff @(posedge clk) begin
		if (data_wr && (data_index < `TS_RAM_WORDS)) begin
			mem[ram_addr_t'(data_index)] <= data_in;
		end
	end

	assign rd_word = ram_addr_t'(rd_addr >> 2);

	// Little-endian lanes. Byte k sits at bits 8*(k%4) of word k/4.
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_byte <= mem[rd_word][8*rd_addr[1:0] +: 8];
		end
	end

	// First word goes out on the request edge itself.
	assign dump_load = ((dump_state == DUMP_IDLE) && pump_req) ||
			((dump_state == DUMP_RUN) && (dump_ptr != `TS_RAM_WORDS));
	assign dump_sel  = (dump_state == DUMP_IDLE) ? '0 : dump_ptr;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dump_state <= DUMP_IDLE;
			dump_ptr   <= '0;
			dump_valid <= 1'b0;
			pump_ready <= 1'b0;
		end else begin
			case (dump_state)
				DUMP_IDLE: begin
					if (pump_req) begin
						pump_ready <= 1'b0;
						dump_valid <= 1'b1;
						dump_ptr   <= ram_addr_t'(1);
						dump_state <= DUMP_RUN;
					end
				end
				DUMP_RUN: begin
					if (dump_ptr == `TS_RAM_WORDS) begin
						dump_valid <= 1'b0;
						pump_ready <= 1'b1; // Held until the next request.
						dump_state <= DUMP_IDLE;
					end else begin
						dump_ptr <= dump_ptr + 1'b1;
					end
				end
				default: dump_state <= DUMP_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (dump_load) begin
			dump_data  <= mem[dump_sel];
			dump_index <= cfg_word_t'(dump_sel);
		end
	end

endmodule

/* logic/ts_header_tracker.sv */
`timescale 1ns/1ps
`include "ts_replace_defines.svh"

module ts_header_tracker import ts_replace_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  ts_byte_t ts_in,
	input  logic     ts_in_valid,
	input  logic     ts_in_sync,
	output logic     d2_valid,
	output ts_byte_t d3_byte,
	output logic     d3_valid,
	output logic     d3_sync,
	output logic     hdr_seen,
	output pid_t     hdr_pid
);

	ts_byte_t d1_byte;
	ts_byte_t d2_byte;
	logic     d1_valid;
	logic     d1_sync;
	logic     d2_sync;

	// Stages shift every clock whether valid or not.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			d1_valid <= 1'b0;
			d2_valid <= 1'b0;
			d3_valid <= 1'b0;
			d1_sync  <= 1'b0;
			d2_sync  <= 1'b0;
			d3_sync  <= 1'b0;
		end else begin
			d1_valid <= ts_in_valid;
			d2_valid <= d1_valid;
			d3_valid <= d2_valid;
			d1_sync  <= ts_in_sync;
			d2_sync  <= d1_sync;
			d3_sync  <= d2_sync;
		end
	end

	always_ff @(posedge clk) begin
		d1_byte <= ts_in;
		d2_byte <= d1_byte;
		d3_byte <= d2_byte;
	end

	// Header is complete once d1 and the input hold both PID bytes.
	assign hdr_seen = d2_valid && d2_sync && (d2_byte == `TS_SYNC_BYTE) &&
			d1_valid && ts_in_valid;
	assign hdr_pid  = {d1_byte[4:0], ts_in};

endmodule

/* logic/ts_replace_defines.svh */
`ifndef TS_REPLACE_DEFINES_SVH
`define TS_REPLACE_DEFINES_SVH

// Transport stream framing.
`define TS_PACKET_BYTES 188
`define TS_SYNC_BYTE    8'h47

`define TS_PID_SLOTS    4
`define TS_DATA_GROUPS  2 // Stored replacement packets.

// Register port width and RAM depth in words.
`define TS_CFG_WIDTH    32
`define TS_RAM_WORDS    (`TS_PACKET_BYTES * `TS_DATA_GROUPS / 4)

`endif

/* logic/ts_replace_pkg.sv */
`include "ts_replace_defines.svh"

package ts_replace_pkg;

	// Packet identifier from the TS header.
	typedef logic [12:0] pid_t;

	typedef logic [7:0] ts_byte_t;

	typedef logic [`TS_CFG_WIDTH-1:0] cfg_word_t;

	// Word address into the replacement RAM.
	typedef logic [$clog2(`TS_RAM_WORDS)-1:0] ram_addr_t;

	// Byte address across all stored groups.
	typedef logic [$clog2(`TS_PACKET_BYTES * `TS_DATA_GROUPS)-1:0] byte_addr_t;

endpackage

/* logic/ts_replacer_top.sv */
`timescale 1ns/1ps

module ts_replacer_top import ts_replace_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      match_enable,
	input  logic      pid_wr,
	input  cfg_word_t pid_index,
	input  cfg_word_t pid_wdata,
	input  logic      data_wr,
	input  cfg_word_t data_index,
	input  cfg_word_t data_in,
	input  logic      pump_req,
	input  ts_byte_t  ts_in,
	input  logic      ts_in_valid,
	input  logic      ts_in_sync,
	output cfg_word_t pid_rdata,
	output logic      pump_ready,
	output logic      dump_valid,
	output cfg_word_t dump_data,
	output cfg_word_t dump_index,
	output ts_byte_t  ts_out,
	output logic      ts_out_valid,
	output logic      ts_out_sync
);

	pid_t       hdr_pid;
	logic       hdr_seen;
	logic       any_match;
	logic       d2_valid;
	ts_byte_t   d3_byte;
	logic       d3_valid;
	logic       d3_sync;
	logic       rd_en;
	byte_addr_t rd_addr;
	ts_byte_t   rd_byte;

	pid_filter_table pid_filter_table_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.pid_wr    (pid_wr),
		.pid_index (pid_index),
		.pid_wdata (pid_wdata),
		.hdr_pid   (hdr_pid),
		.pid_rdata (pid_rdata),
		.any_match (any_match)
	);

	ts_header_tracker ts_header_tracker_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.ts_in       (ts_in),
		.ts_in_valid (ts_in_valid),
		.ts_in_sync  (ts_in_sync),
		.d2_valid    (d2_valid),
		.d3_byte     (d3_byte),
		.d3_valid    (d3_valid),
		.d3_sync     (d3_sync),
		.hdr_seen    (hdr_seen),
		.hdr_pid     (hdr_pid)
	);

	replace_packet_ram replace_packet_ram_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.data_wr    (data_wr),
		.data_index (data_index),
		.data_in    (data_in),
		.pump_req   (pump_req),
		.rd_en      (rd_en),
		.rd_addr    (rd_addr),
		.rd_byte    (rd_byte),
		.pump_ready (pump_ready),
		.dump_valid (dump_valid),
		.dump_data  (dump_data),
		.dump_index (dump_index)
	);

	ts_splicer ts_splicer_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.match_enable (match_enable),
		.any_match    (any_match),
		.hdr_seen     (hdr_seen),
		.d2_valid     (d2_valid),
		.d3_byte      (d3_byte),
		.d3_valid     (d3_valid),
		.d3_sync      (d3_sync),
		.rd_byte      (rd_byte),
		.rd_en        (rd_en),
		.rd_addr      (rd_addr),
		.ts_out       (ts_out),
		.ts_out_valid (ts_out_valid),
		.ts_out_sync  (ts_out_sync)
	);

endmodule

/* logic/ts_splicer.sv */
`timescale 1ns/1ps
`include "ts_replace_defines.svh"

module ts_splicer import ts_replace_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       match_enable,
	input  logic       any_match,
	input  logic       hdr_seen,
	input  logic       d2_valid,
	input  ts_byte_t   d3_byte,
	input  logic       d3_valid,
	input  logic       d3_sync,
	input  ts_byte_t   rd_byte,
	output logic       rd_en,
	output byte_addr_t rd_addr,
	output ts_byte_t   ts_out,
	output logic       ts_out_valid,
	output logic       ts_out_sync
);

	localparam int GRP_W    = (`TS_DATA_GROUPS > 1) ? $clog2(`TS_DATA_GROUPS) : 1;
	localparam int CNT_W    = $clog2(`TS_PACKET_BYTES);
	localparam int PKT_LAST = `TS_PACKET_BYTES - 1;
	localparam int GRP_LAST = `TS_DATA_GROUPS - 1;

	logic [GRP_W-1:0] next_grp;
	logic [GRP_W-1:0] cur_grp;
	logic [GRP_W-1:0] addr_grp;
	logic [CNT_W-1:0] byte_cnt;
	logic [CNT_W-1:0] addr_cnt;
	logic             replacing;
	logic             start;
	logic             sel_ram;

	assign start = hdr_seen && any_match && match_enable;

	// Header cycle has byte 0 in d2, so its read is issued directly.
	assign rd_en    = start || (replacing && d2_valid);
	assign addr_grp = start ? next_grp : cur_grp;
	assign addr_cnt = start ? '0 : byte_cnt;
	assign rd_addr  = byte_addr_t'(addr_grp * `TS_PACKET_BYTES + addr_cnt);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			replacing    <= 1'b0;
			byte_cnt     <= '0;
			cur_grp      <= '0;
			next_grp     <= '0;
			sel_ram      <= 1'b0;
			ts_out_valid <= 1'b0;
			ts_out_sync  <= 1'b0;
		end else begin
			sel_ram      <= rd_en; // RAM byte lands with d3.
			ts_out_valid <= d3_valid;
			ts_out_sync  <= d3_sync;
			if (hdr_seen) begin
				replacing <= start;
				byte_cnt  <= CNT_W'(1);
				if (start) begin
					cur_grp  <= next_grp;
					next_grp <= (next_grp == GRP_W'(GRP_LAST)) ? '0 : next_grp + 1'b1;
				end
			end else if (replacing && d2_valid) begin
				byte_cnt <= byte_cnt + 1'b1;
				if (byte_cnt == CNT_W'(PKT_LAST)) begin
					replacing <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		ts_out <= sel_ram ? rd_byte : d3_byte;
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module ts_replacer_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vts_replacer_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "ALL TESTS PASSED" "$LOG"; then
	exit 0
fi
exit 1

/* verif/ts_replacer_tb.sv */
`timescale 1ns/1ps
`include "ts_replace_defines.svh"

module ts_replacer_tb import ts_replace_pkg::*; ();

	localparam int PKT    = `TS_PACKET_BYTES;
	localparam int WORDS  = `TS_RAM_WORDS;
	localparam int SLOTS  = `TS_PID_SLOTS;
	localparam int GROUPS = `TS_DATA_GROUPS;

	logic      clk;
	logic      rst_n;
	logic      match_enable;
	logic      pid_wr;
	cfg_word_t pid_index;
	cfg_word_t pid_wdata;
	logic      data_wr;
	cfg_word_t data_index;
	cfg_word_t data_in;
	logic      pump_req;
	ts_byte_t  ts_in;
	logic      ts_in_valid;
	logic      ts_in_sync;
	cfg_word_t pid_rdata;
	logic      pump_ready;
	logic      dump_valid;
	cfg_word_t dump_data;
	cfg_word_t dump_index;
	ts_byte_t  ts_out;
	logic      ts_out_valid;
	logic      ts_out_sync;

	// Model of the PID table, the RAM and the rotating group.
	pid_t        model_pid [SLOTS];
	logic        model_en [SLOTS];
	cfg_word_t   model_ram [WORDS];
	int          model_grp;
	logic [31:0] rng_state;
	ts_byte_t    exp_byte_q [$];
	logic        exp_sync_q [$];
	ts_byte_t    chk_byte;
	logic        chk_sync;
	int          mismatches;
	int          failures;

	ts_replacer_top ts_replacer_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic logic pid_hit(input pid_t pid);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < SLOTS; i++) begin
			if (model_en[i] && (model_pid[i] == pid)) begin
				hit = 1'b1;
			end
		end
		return hit;
	endfunction

	// Replaced packets take byte pos of the group and all others pass unchanged.
	function automatic ts_byte_t expected_byte(input pid_t pid, input logic me, input int grp,
			input int pos, input ts_byte_t in_byte);
		int        k;
		cfg_word_t word;
		if (!(me && pid_hit(pid))) begin
			return in_byte;
		end
		k = grp * PKT + pos;
		word = model_ram[k / 4];
		return word[8 * (k % 4) +: 8]; // Little-endian lanes.
	endfunction

	function automatic pid_t free_pid();
		pid_t p;
		p = pid_t'(next_rand());
		while (pid_hit(p)) begin
			p = pid_t'(next_rand());
		end
		return p;
	endfunction

	task automatic write_pid(input int idx, input cfg_word_t data);
		@(negedge clk);
		pid_wr    <= 1'b1;
		pid_index <= cfg_word_t'(idx);
		pid_wdata <= data;
		@(negedge clk);
		pid_wr <= 1'b0;
		if (idx < SLOTS) begin
			model_pid[idx] = data[12:0];
			model_en[idx]  = data[16];
		end
	endtask

	task automatic read_pid_check(input int idx);
		cfg_word_t want;
		want = '0;
		if (idx < SLOTS) begin
			want[12:0] = model_pid[idx];
			want[16]   = model_en[idx];
		end
		@(negedge clk);
		pid_index <= cfg_word_t'(idx);
		@(posedge clk);
		assert (pid_rdata == want) else begin
			mismatches++;
			$display("MISMATCH t=%0t pid_rdata[%0d] expected %h actual %h", $time, idx, want,
					pid_rdata);
		end
	endtask

	task automatic fill_ram();
		cfg_word_t w;
		for (int i = 0; i <= WORDS; i++) begin
			w = next_rand();
			@(negedge clk);
			data_wr    <= 1'b1;
			data_index <= (i < WORDS) ? cfg_word_t'(i) : cfg_word_t'(32'h8000_0000);
			data_in    <= w;
			if (i < WORDS) begin
				model_ram[i] = w; // Last write is out of range.
			end
		end
		@(negedge clk);
		data_wr <= 1'b0;
	endtask

	task automatic check_dump();
		int cycles;
		int nwords;
		@(negedge clk);
		pump_req <= 1'b1;
		@(negedge clk);
		pump_req <= 1'b0;
		cycles = 0;
		nwords = 0;
		while (!pump_ready && cycles < 4 * WORDS) begin
			if (dump_valid) begin
				assert (dump_index == cfg_word_t'(nwords)) else begin
					mismatches++;
					$display("MISMATCH t=%0t dump_index expected %0d actual %0d", $time, nwords,
							dump_index);
				end
				if (nwords < WORDS) begin
					assert (dump_data == model_ram[nwords]) else begin
						mismatches++;
						$display("MISMATCH t=%0t dump_data expected %h actual %h", $time,
								model_ram[nwords], dump_data);
					end
				end
				nwords++;
			end
			@(negedge clk);
			cycles++;
		end
		if (!pump_ready) begin
			failures++;
			$display("Timeout: pump_ready did not rise after the dump request");
		end
		assert (nwords == WORDS) else begin
			failures++;
			$display("Dump gave %0d words instead of %0d", nwords, WORDS);
		end
	endtask

	task automatic idle_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			ts_in_valid <= 1'b0;
			ts_in_sync  <= 1'b0;
			ts_in       <= ts_byte_t'(next_rand());
		end
	endtask

	task automatic send_packet(input pid_t pid);
		ts_byte_t    pkt [PKT];
		logic [31:0] r;
		int          grp;
		r = next_rand();
		pkt[0] = `TS_SYNC_BYTE;
		pkt[1] = {r[7:5], pid[12:8]};
		pkt[2] = pid[7:0];
		for (int i = 3; i < PKT; i++) begin
			r = next_rand();
			pkt[i] = r[7:0];
		end
		grp = model_grp;
		if (match_enable && pid_hit(pid)) begin
			model_grp = (model_grp + 1) % GROUPS;
		end
		for (int i = 0; i < PKT; i++) begin
			@(negedge clk);
			ts_in       <= pkt[i];
			ts_in_valid <= 1'b1;
			ts_in_sync  <= (i == 0);
			exp_byte_q.push_back(expected_byte(pid, match_enable, grp, i, pkt[i]));
			exp_sync_q.push_back(i == 0);
		end
	endtask

	task automatic drain_output();
		int cycles;
		idle_cycles(1);
		cycles = 0;
		while (exp_byte_q.size() != 0 && cycles < 50) begin
			@(negedge clk);
			cycles++;
		end
		if (exp_byte_q.size() != 0) begin
			failures++;
			$display("Timeout: %0d expected output bytes never appeared", exp_byte_q.size());
		end
	endtask

	// Outputs settle after the rising edge.
	always @(negedge clk) begin
		if (rst_n && ts_out_valid) begin
			if (exp_byte_q.size() == 0) begin
				failures++;
				$display("Output byte at %0t with nothing expected", $time);
			end else begin
				chk_byte = exp_byte_q.pop_front();
				chk_sync = exp_sync_q.pop_front();
				assert (ts_out == chk_byte) else begin
					mismatches++;
					$display("MISMATCH t=%0t ts_out expected %h actual %h", $time, chk_byte, ts_out);
				end
				assert (ts_out_sync == chk_sync) else begin
					mismatches++;
					$display("MISMATCH t=%0t ts_out_sync expected %b actual %b", $time, chk_sync,
							ts_out_sync);
				end
			end
		end
	end

	initial begin
		int slot;
		rng_state    = 32'h8a25b1e9;
		mismatches   = 0;
		failures     = 0;
		model_grp    = 0;
		rst_n        = 1'b0;
		match_enable = 1'b0;
		pid_wr       = 1'b0;
		pid_index    = '0;
		pid_wdata    = '0;
		data_wr      = 1'b0;
		data_index   = '0;
		data_in      = '0;
		pump_req     = 1'b0;
		ts_in        = '0;
		ts_in_valid  = 1'b0;
		ts_in_sync   = 1'b0;
		for (int i = 0; i < SLOTS; i++) begin
			model_pid[i] = '0;
			model_en[i]  = 1'b0;
		end
		repeat (16) @(negedge clk);
		rst_n <= 1'b1;

		// Random words check the zero padding of the readback.
		for (int i = 0; i <= SLOTS; i++) begin
			write_pid(i, next_rand());
		end
		for (int i = 0; i <= SLOTS; i++) begin
			read_pid_check(i);
		end

		fill_ram();
		check_dump();

		// Slots 0 and 2 enabled.
		for (int i = 0; i < SLOTS; i++) begin
			write_pid(i, {15'd0, (i % 2 == 0), 3'd0, pid_t'(next_rand())});
		end
		match_enable = 1'b1;
		for (int i = 0; i < 6; i++) begin
			send_packet(free_pid());
			idle_cycles(int'(next_rand() % 4));
		end
		drain_output();

		for (int i = 0; i < 10; i++) begin
			slot = (next_rand() % 2 != 0) ? 0 : 2;
			if (i % 3 != 1) begin
				send_packet(model_pid[slot]);
			end else begin
				send_packet(free_pid());
			end
			idle_cycles(int'(next_rand() % 4));
		end
		drain_output();

		match_enable = 1'b0;
		for (int i = 0; i < 3; i++) begin
			send_packet(model_pid[0]);
			idle_cycles(int'(next_rand() % 3));
		end
		drain_output();

		match_enable = 1'b1;
		write_pid(0, {15'd0, 1'b0, 3'd0, model_pid[0]});
		write_pid(2, {15'd0, 1'b0, 3'd0, model_pid[2]});
		for (int i = 0; i < 3; i++) begin
			send_packet(model_pid[(i % 2 == 0) ? 0 : 2]);
			idle_cycles(int'(next_rand() % 3));
		end
		drain_output();

		// Group must resume where it stood before gating.
		write_pid(0, {15'd0, 1'b1, 3'd0, model_pid[0]});
		send_packet(model_pid[0]);
		send_packet(model_pid[0]);
		drain_output();

		assert (exp_byte_q.size() == 0) else begin
			failures++;
			$display("Expected queue still holds %0d bytes", exp_byte_q.size());
		end
		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule
